// ==== nes_pad_pkg.sv ====
package nes_pad_pkg;

	////////////////////
	// Pad waveform timing
	////////////////////

	// clk_50M cycles in one microsecond
	localparam logic [5:0] CYCLES_PER_US = 6'd50;
	// Latch pulse width, 12 us
	localparam logic [9:0] LATCH_CYCLES = 10'd600;
	// One pulse phase, low or high, 6 us
	localparam logic [8:0] HALF_BIT_CYCLES = 9'd300;
	// Bits shifted out of one pad
	localparam int NUM_BUTTONS = 8;

	////////////////////
	// Encodings
	////////////////////

	// APB byte offsets
	typedef enum logic [7:0] {
		REG_CTRL    = 8'h00,
		REG_PERIOD  = 8'h04,
		REG_MASK    = 8'h08,
		REG_BUTTONS = 8'h0C,
		REG_PRESSED = 8'h10,
		REG_FRAMES  = 8'h14
	} pad_reg_e;

	// Reader FSM
	typedef enum logic [1:0] {
		RD_IDLE,
		RD_LATCH,
		RD_PULSE_LOW,
		RD_PULSE_HIGH
	} reader_state_e;

	////////////////////
	// Bundles
	////////////////////

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// Start is a single-cycle strobe
	typedef struct packed {
		logic        enable;
		logic        start;
		logic [15:0] period_us;
	} pad_cfg_t;

	// Buttons only meaningful while valid is high
	typedef struct packed {
		logic                   valid;
		logic [NUM_BUTTONS-1:0] buttons;
	} pad_frame_t;

	typedef struct packed {
		logic [NUM_BUTTONS-1:0] buttons;
		logic [NUM_BUTTONS-1:0] pressed;
		logic [15:0]            frame_count;
	} pad_status_t;

endpackage

// ==== nes_pad_reader.sv ====
module nes_pad_reader (
	input  logic                    clk_50M,
	input  logic                    rst,
	input  nes_pad_pkg::pad_cfg_t   cfg,
	input  logic                    pad_data,
	output logic                    pad_latch,
	output logic                    pad_pulse,
	output nes_pad_pkg::pad_frame_t frame
);
	import nes_pad_pkg::*;

	// Poll timer
	logic [5:0]  us_cnt;
	logic [15:0] period_cnt;
	logic        us_tick;
	logic        poll_req;
	logic        frame_req;
	logic        pending;

	// Waveform FSM
	reader_state_e state;
	reader_state_e state_next;
	logic [9:0]    phase;
	logic          phase_done;
	logic [2:0]    bit_idx;
	logic          frame_start;
	logic          frame_end;
	logic          pulse_fall;
	logic          valid_q;

	// Serial sampling
	logic [1:0]             data_sync;
	logic [NUM_BUTTONS-1:0] shift;

	////////////////////
	// Poll timer
	////////////////////

	// Microsecond prescaler, idle while disabled
	assign us_tick = cfg.enable && (us_cnt == CYCLES_PER_US - 6'd1);

	always_ff @(posedge clk_50M)
	begin
		if (rst || !cfg.enable)
			us_cnt <= '0;
		else if (us_tick)
			us_cnt <= '0;
		else
			us_cnt <= us_cnt + 6'd1;
	end

	// Request at the last microsecond of each period
	// Period 0 means no periodic polling
	assign poll_req = us_tick && (cfg.period_us != 16'd0)
		&& (period_cnt >= cfg.period_us - 16'd1);

	always_ff @(posedge clk_50M)
	begin
		if (rst || !cfg.enable || cfg.period_us == 16'd0)
			period_cnt <= '0;
		else if (poll_req)
			period_cnt <= '0;
		else if (us_tick)
			period_cnt <= period_cnt + 16'd1;
	end

	// Timer or software trigger
	assign frame_req = cfg.start || poll_req;
	assign frame_start = (state == RD_IDLE) && (frame_req || pending);

	// Hold a request that lands mid-frame
	always_ff @(posedge clk_50M)
	begin
		if (rst)
			pending <= 1'b0;
		else if (frame_start)
			pending <= 1'b0;
		else if (frame_req)
			pending <= 1'b1;
	end

	////////////////////
	// Latch / pulse FSM
	////////////////////

	always_comb
	begin
		unique case (state)
			RD_LATCH:      phase_done = (phase == LATCH_CYCLES - 10'd1);
			RD_PULSE_LOW:  phase_done = (phase == {1'b0, HALF_BIT_CYCLES - 9'd1});
			RD_PULSE_HIGH: phase_done = (phase == {1'b0, HALF_BIT_CYCLES - 9'd1});
			default:       phase_done = 1'b0;
		endcase
	end

	always_comb
	begin
		state_next = state;
		unique case (state)
			RD_IDLE:
				if (frame_start)
					state_next = RD_LATCH;
			RD_LATCH:
				if (phase_done)
					state_next = RD_PULSE_LOW;
			RD_PULSE_LOW:
				if (phase_done)
					state_next = RD_PULSE_HIGH;
			RD_PULSE_HIGH:
				if (phase_done)
				begin
					// Last slot closes the frame
					if (bit_idx == 3'(NUM_BUTTONS - 1))
						state_next = RD_IDLE;
					else
						state_next = RD_PULSE_LOW;
				end
			default:
				state_next = RD_IDLE;
		endcase
	end

	// Falling pulse edge opens a bit slot
	assign pulse_fall = (state_next == RD_PULSE_LOW) && (state != RD_PULSE_LOW);
	assign frame_end = (state == RD_PULSE_HIGH) && (state_next == RD_IDLE);

	always_ff @(posedge clk_50M)
	begin
		if (rst)
		begin
			state <= RD_IDLE;
			phase <= '0;
			bit_idx <= '0;
			pad_latch <= 1'b0;
			pad_pulse <= 1'b1;
			valid_q <= 1'b0;
		end
		else
		begin
			state <= state_next;
			// Pins registered from next state, glitch free
			pad_latch <= (state_next == RD_LATCH);
			pad_pulse <= (state_next != RD_PULSE_LOW);
			// Lands 5400 cycles after first latch cycle
			valid_q <= frame_end;
			// Phase restarts on each state change
			if (state_next != state || state == RD_IDLE)
				phase <= '0;
			else
				phase <= phase + 10'd1;
			if (state == RD_LATCH)
				bit_idx <= '0;
			else if (state == RD_PULSE_HIGH && phase_done)
				bit_idx <= bit_idx + 3'd1;
		end
	end

	////////////////////
	// Serial capture
	////////////////////

	// Two-flop synchronizer, pad data is async
	always_ff @(posedge clk_50M)
	begin
		data_sync <= {data_sync[0], pad_data};
	end

	// Active-low data, A arrives first and ends in bit 7
	always_ff @(posedge clk_50M)
	begin
		if (pulse_fall)
			shift <= {shift[NUM_BUTTONS-2:0], ~data_sync[1]};
	end

	assign frame.valid = valid_q;
	assign frame.buttons = shift;

endmodule

// ==== nes_pad_sub.sv ====
module nes_pad_sub (
	input  logic                  clk_50M,
	input  logic                  rst,
	input  nes_pad_pkg::apb_req_t apb_req,
	input  logic                  pad_data,
	output nes_pad_pkg::apb_rsp_t apb_rsp,
	output logic                  pad_latch,
	output logic                  pad_pulse,
	output logic                  irq
);
	import nes_pad_pkg::*;

	// Between blocks
	pad_cfg_t    cfg;
	pad_frame_t  frame;
	pad_status_t status;
	logic [7:0]  clear_mask;
	logic [7:0]  irq_mask;

	// APB registers
	pad_regs i_pad_regs (
		.clk_50M    (clk_50M),
		.rst        (rst),
		.apb_req    (apb_req),
		.status     (status),
		.apb_rsp    (apb_rsp),
		.cfg        (cfg),
		.clear_mask (clear_mask),
		.irq_mask   (irq_mask)
	);

	// Serial link to the pad
	nes_pad_reader i_nes_pad_reader (
		.clk_50M   (clk_50M),
		.rst       (rst),
		.cfg       (cfg),
		.pad_data  (pad_data),
		.pad_latch (pad_latch),
		.pad_pulse (pad_pulse),
		.frame     (frame)
	);

	// Press flags, frame count, interrupt
	pad_events i_pad_events (
		.clk_50M    (clk_50M),
		.rst        (rst),
		.frame      (frame),
		.clear_mask (clear_mask),
		.irq_mask   (irq_mask),
		.status     (status),
		.irq        (irq)
	);

endmodule

// ==== pad_events.sv ====
module pad_events (
	input  logic                     clk_50M,
	input  logic                     rst,
	input  nes_pad_pkg::pad_frame_t  frame,
	input  logic [7:0]               clear_mask,
	input  logic [7:0]               irq_mask,
	output nes_pad_pkg::pad_status_t status,
	output logic                     irq
);
	import nes_pad_pkg::*;

	logic [NUM_BUTTONS-1:0] new_press;
	logic [NUM_BUTTONS-1:0] pressed_next;

	////////////////////
	// Press detection
	////////////////////

	// Rising edges against the previous frame
	assign new_press = frame.valid ? (frame.buttons & ~status.buttons) : '0;

	// W1C clear first, then set, so a new press survives a clear
	assign pressed_next = (status.pressed & ~clear_mask) | new_press;

	////////////////////
	// Status and interrupt
	////////////////////

	always_ff @(posedge clk_50M)
	begin
		if (rst)
		begin
			status <= '0;
			irq <= 1'b0;
		end
		else
		begin
			status.pressed <= pressed_next;
			// New frame replaces the button image
			if (frame.valid)
			begin
				status.buttons <= frame.buttons;
				// Wraps at 16 bits
				status.frame_count <= status.frame_count + 16'd1;
			end
			// Follows the sticky flags one cycle later
			irq <= |(status.pressed & irq_mask);
		end
	end

endmodule

// ==== pad_regs.sv ====
module pad_regs (
	input  logic                     clk_50M,
	input  logic                     rst,
	input  nes_pad_pkg::apb_req_t    apb_req,
	input  nes_pad_pkg::pad_status_t status,
	output nes_pad_pkg::apb_rsp_t    apb_rsp,
	output nes_pad_pkg::pad_cfg_t    cfg,
	output logic [7:0]               clear_mask,
	output logic [7:0]               irq_mask
);
	import nes_pad_pkg::*;

	pad_reg_e    reg_addr;
	logic        access;
	logic        wr_en;
	logic        mapped;
	logic [31:0] rdata;

	// Configuration
	logic        enable_q;
	logic [15:0] period_q;
	logic [7:0]  mask_q;

	// Single-cycle strobes
	logic        start_q;
	logic [7:0]  clear_q;

	////////////////////
	// APB decode
	////////////////////

	assign reg_addr = pad_reg_e'(apb_req.paddr);

	// Access phase, no wait states
	assign access = apb_req.psel && apb_req.penable;
	assign wr_en = access && apb_req.pwrite;

	// Read mux and address check
	always_comb
	begin
		mapped = 1'b1;
		rdata = '0;
		case (reg_addr)
			// Start bit never reads back
			REG_CTRL:    rdata = {31'd0, enable_q};
			REG_PERIOD:  rdata = {16'd0, period_q};
			REG_MASK:    rdata = {24'd0, mask_q};
			REG_BUTTONS: rdata = {24'd0, status.buttons};
			REG_PRESSED: rdata = {24'd0, status.pressed};
			REG_FRAMES:  rdata = {16'd0, status.frame_count};
			default:     mapped = 1'b0;
		endcase
	end

	////////////////////
	// Register writes
	////////////////////

	always_ff @(posedge clk_50M)
	begin
		if (rst)
		begin
			enable_q <= 1'b0;
			period_q <= '0;
			mask_q <= '0;
			start_q <= 1'b0;
			clear_q <= '0;
		end
		else
		begin
			// Strobes last one cycle
			start_q <= 1'b0;
			clear_q <= '0;
			if (wr_en && mapped)
			begin
				case (reg_addr)
					REG_CTRL:
					begin
						enable_q <= apb_req.pwdata[0];
						start_q <= apb_req.pwdata[1];
					end
					REG_PERIOD:
						period_q <= apb_req.pwdata[15:0];
					REG_MASK:
						mask_q <= apb_req.pwdata[7:0];
					// Write 1 to clear
					REG_PRESSED:
						clear_q <= apb_req.pwdata[7:0];
					// Buttons and frames are read only
					default:
						;
				endcase
			end
		end
	end

	////////////////////
	// Outputs
	////////////////////

	assign cfg.enable = enable_q;
	assign cfg.start = start_q;
	assign cfg.period_us = period_q;

	assign clear_mask = clear_q;
	assign irq_mask = mask_q;

	assign apb_rsp.prdata = rdata;
	assign apb_rsp.pready = 1'b1;
	// Error only in the access phase
	assign apb_rsp.pslverr = access && !mapped;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the NES pad testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
	--top-module tb_nes_pad_sub -f vlog.f -o tb_nes_pad_sub
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/tb_nes_pad_sub)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -q -F "*** TEST PASSED ***"; then
	exit 0
fi
exit 1

// ==== tb_nes_pad_sub.sv ====
module tb_nes_pad_sub;
	timeunit 1ns;
	timeprecision 1ps;
	import nes_pad_pkg::*;

	// Serial frame is 600 + 8 x 600 cycles
	localparam int FRAME_CYCLES = 5400;
	localparam int PERIOD_US = 200;
	localparam int PERIOD_CYCLES = PERIOD_US * 50;
	// Periods counted in the polling test
	localparam int POLL_FRAMES = 3;
	// Frames per test with idle windows counted as frames
	localparam int FRAME_SLOTS = 4 + 5 + 4 + 2 + 11;
	// 20 ns per cycle plus half again as margin
	localparam int WATCHDOG_NS = FRAME_SLOTS * FRAME_CYCLES * 20 * 3 / 2;
	localparam int POLL_LIMIT = 2 * FRAME_CYCLES / 3;
	localparam bit PIN_LATCH = 1'b0;
	localparam bit PIN_PULSE = 1'b1;

	logic     clk_50M;
	logic     rst;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	logic     pad_data;
	logic     pad_latch;
	logic     pad_pulse;
	logic     irq;

	// Buttons held down on the pad model
	logic [7:0] pad_buttons;

	// Expected state from the register rules
	logic [7:0]  last_buttons;
	logic [7:0]  exp_pressed;
	logic [7:0]  exp_mask;
	int          expected_frames;
	logic [15:0] lfsr_state;

	nes_pad_sub i_nes_pad_sub (
		.clk_50M   (clk_50M),
		.rst       (rst),
		.apb_req   (apb_req),
		.pad_data  (pad_data),
		.apb_rsp   (apb_rsp),
		.pad_latch (pad_latch),
		.pad_pulse (pad_pulse),
		.irq       (irq)
	);

	tb_pad_model i_pad_model (
		.pad_latch (pad_latch),
		.pad_pulse (pad_pulse),
		.buttons   (pad_buttons),
		.pad_data  (pad_data)
	);

	// 50 MHz
	initial
	begin
		clk_50M = 1'b0;
		forever
			#10 clk_50M = ~clk_50M;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("*** TEST FAILED ***");
		$fatal(1, "watchdog expired");
	end

	////////////////////
	// Compare tasks
	////////////////////

	task automatic check_word(input logic [31:0] got, input logic [31:0] expected,
		input string what);
		if (got !== expected)
		begin
			$display("CHECK FAILED at %0d ns: %s, got 0x%0h, expected 0x%0h",
				$time, what, got, expected);
			$display("*** TEST FAILED ***");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic check_bit(input logic got, input logic expected, input string what);
		if (got !== expected)
		begin
			$display("CHECK FAILED at %0d ns: %s, got %b, expected %b",
				$time, what, got, expected);
			$display("*** TEST FAILED ***");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("Timeout at %0d ns: gave up waiting for %s", $time, what);
		$display("*** TEST FAILED ***");
		$fatal(1, "wait limit reached");
	endtask

	////////////////////
	// APB master
	////////////////////

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		@(posedge clk_50M);
		#2;
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = 1'b1;
		apb_req.paddr = addr;
		apb_req.pwdata = data;
		@(posedge clk_50M);
		#2;
		apb_req.penable = 1'b1;
		#5;
		check_bit(apb_rsp.pready, 1'b1, "pready during write access");
		// Write lands on this edge
		@(posedge clk_50M);
		#2;
		apb_req = '0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
		output logic err);
		@(posedge clk_50M);
		#2;
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = 1'b0;
		apb_req.paddr = addr;
		@(posedge clk_50M);
		#2;
		apb_req.penable = 1'b1;
		// Combinational read data sampled mid access phase
		#5;
		data = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		check_bit(apb_rsp.pready, 1'b1, "pready during read access");
		@(posedge clk_50M);
		#2;
		apb_req = '0;
	endtask

	task automatic read_check(input logic [7:0] addr, input logic [31:0] expected,
		input string what);
		logic [31:0] data;
		logic        err;
		apb_read(addr, data, err);
		check_bit(err, 1'b0, {what, ", pslverr"});
		check_word(data, expected, what);
	endtask

	////////////////////
	// Helpers
	////////////////////

	// Galois LFSR with x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic next_random_bit();
		logic out_bit;
		out_bit = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out_bit)
			lfsr_state = lfsr_state ^ 16'hB400;
		return out_bit;
	endfunction

	function automatic logic [7:0] random_byte();
		logic [7:0] value;
		value = '0;
		for (int i = 0; i < 8; i++)
			value = {value[6:0], next_random_bit()};
		return value;
	endfunction

	function automatic logic pin_level(input bit pin);
		return pin ? pad_pulse : pad_latch;
	endfunction

	// Pins move on the rising edge so look 1 ns later
	task automatic wait_pin(input bit pin, input logic level, input int limit,
		input string what);
		int cycles;
		cycles = 0;
		while (pin_level(pin) !== level)
		begin
			if (cycles >= limit)
				timeout_fail(what);
			@(posedge clk_50M);
			#1;
			cycles++;
		end
	endtask

	// Cycles the pin stays at level up to limit
	task automatic run_length(input bit pin, input logic level, input int limit,
		output int cycles);
		cycles = 0;
		while (pin_level(pin) === level && cycles < limit)
		begin
			@(posedge clk_50M);
			#1;
			cycles++;
		end
	endtask

	// No frame may start while the bus is idle
	task automatic hold_check(input int cycles);
		for (int i = 0; i < cycles; i++)
		begin
			@(posedge clk_50M);
			#1;
			check_bit(pad_latch, 1'b0, "latch stays low while idle");
			check_bit(pad_pulse, 1'b1, "pulse stays high while idle");
		end
	endtask

	// Poll the frame counter until it reaches the expected count
	task automatic wait_frames();
		logic [31:0] data;
		logic        err;
		int          polls;
		polls = 0;
		apb_read(REG_FRAMES, data, err);
		while (data[15:0] != 16'(expected_frames))
		begin
			polls++;
			if (polls > POLL_LIMIT)
				timeout_fail("the frame counter to advance");
			apb_read(REG_FRAMES, data, err);
		end
	endtask

	// One software-triggered frame with the given buttons held
	task automatic capture(input logic [7:0] pattern);
		pad_buttons = pattern;
		apb_write(REG_CTRL, 32'h2);
		expected_frames++;
		wait_frames();
		// Sticky flags collect 0 to 1 changes
		exp_pressed = exp_pressed | (pattern & ~last_buttons);
		last_buttons = pattern;
		read_check(REG_BUTTONS, {24'd0, pattern}, "buttons after frame");
		read_check(REG_PRESSED, {24'd0, exp_pressed}, "pressed flags after frame");
	endtask

	task automatic clear_pressed(input logic [7:0] bits);
		apb_write(REG_PRESSED, {24'd0, bits});
		exp_pressed = exp_pressed & ~bits;
	endtask

	// irq trails the flags by one registered stage
	task automatic irq_check(input string what);
		repeat (2) @(posedge clk_50M);
		#1;
		check_bit(irq, |(exp_pressed & exp_mask), what);
	endtask

	////////////////////
	// Directed tests
	////////////////////

	task automatic test_reset_regs();
		logic [31:0] data;
		logic        err;
		check_bit(pad_latch, 1'b0, "latch low after reset");
		check_bit(pad_pulse, 1'b1, "pulse high after reset");
		check_bit(irq, 1'b0, "irq low after reset");
		for (int a = 0; a <= 20; a += 4)
			read_check(8'(a), 32'd0, $sformatf("offset 0x%0h after reset", a));
		// Upper bits are not stored
		apb_write(REG_PERIOD, 32'hABCD_1234);
		apb_write(REG_MASK, 32'h0000_C3A5);
		read_check(REG_PERIOD, 32'h0000_1234, "period readback");
		read_check(REG_MASK, 32'h0000_00A5, "mask readback");
		apb_read(8'h18, data, err);
		check_bit(err, 1'b1, "pslverr on offset 0x18");
		// Unmapped write is dropped
		apb_write(8'h18, 32'hFFFF_FFFF);
		read_check(REG_PERIOD, 32'h0000_1234, "period after unmapped write");
		read_check(REG_MASK, 32'h0000_00A5, "mask after unmapped write");
		apb_write(REG_PERIOD, 32'd0);
		apb_write(REG_MASK, 32'd0);
	endtask

	task automatic test_frame_waveform();
		int n;
		apb_write(REG_CTRL, 32'h2);
		expected_frames++;
		wait_pin(PIN_LATCH, 1'b1, 10, "latch after a start write");
		check_bit(pad_pulse, 1'b1, "pulse high during latch");
		run_length(PIN_LATCH, 1'b1, 2000, n);
		check_word(32'(n), 32'd600, "latch width in cycles");
		for (int k = 0; k < 8; k++)
		begin
			run_length(PIN_PULSE, 1'b0, 2000, n);
			check_word(32'(n), 32'd300, $sformatf("pulse low width, slot %0d", k));
			check_bit(pad_latch, 1'b0, "latch low during pulses");
			if (k < 7)
			begin
				run_length(PIN_PULSE, 1'b1, 2000, n);
				check_word(32'(n), 32'd300, $sformatf("pulse high width, slot %0d", k));
			end
		end
		// Last high phase runs into idle with enable off
		hold_check(2 * FRAME_CYCLES);
		read_check(REG_FRAMES, 32'(expected_frames), "frame count after one shot");
		read_check(REG_CTRL, 32'd0, "start bit reads 0");
	endtask

	task automatic test_button_capture();
		// A alone must land in bit 7
		capture(8'h80);
		for (int i = 0; i < 4; i++)
			capture(random_byte());
		read_check(REG_FRAMES, 32'(expected_frames), "frame count after captures");
		irq_check("irq low with mask 0");
	endtask

	task automatic test_sticky_press();
		clear_pressed(8'hFF);
		read_check(REG_PRESSED, 32'd0, "pressed after full clear");
		capture(8'h81);
		// Buttons held across a clear raise no new flag
		clear_pressed(8'h81);
		capture(8'h83);
		capture(8'h0F);
		// Released buttons keep their flags
		capture(8'h00);
		clear_pressed(8'h06);
		read_check(REG_PRESSED, {24'd0, exp_pressed}, "pressed after partial clear");
		clear_pressed(8'hFF);
		read_check(REG_PRESSED, 32'd0, "pressed after second clear");
	endtask

	task automatic test_irq_mask();
		apb_write(REG_MASK, 32'h40);
		exp_mask = 8'h40;
		clear_pressed(8'hFF);
		irq_check("irq low with no flags");
		// Right is outside the mask
		capture(8'h01);
		irq_check("irq after unmasked press");
		capture(8'h41);
		irq_check("irq after masked press of B");
		clear_pressed(8'h40);
		irq_check("irq after clearing B");
		apb_write(REG_MASK, 32'd0);
		exp_mask = 8'h00;
	endtask

	task automatic test_periodic_poll();
		read_check(REG_FRAMES, 32'(expected_frames), "frame count before polling");
		apb_write(REG_PERIOD, 32'(PERIOD_US));
		apb_write(REG_CTRL, 32'h1);
		read_check(REG_CTRL, 32'h1, "enable readback");
		wait_pin(PIN_LATCH, 1'b1, 2 * PERIOD_CYCLES, "the first polled latch");
		// Between the end of frame N and the start of frame N+1
		repeat (POLL_FRAMES * PERIOD_CYCLES - PERIOD_CYCLES / 4) @(posedge clk_50M);
		#2;
		expected_frames += POLL_FRAMES;
		read_check(REG_FRAMES, 32'(expected_frames), "frame count after polling");
		apb_write(REG_CTRL, 32'h0);
		hold_check(2 * PERIOD_CYCLES);
		read_check(REG_FRAMES, 32'(expected_frames), "frame count after disable");
	endtask

	////////////////////
	// Sequence
	////////////////////

	initial
	begin
		rst = 1'b1;
		apb_req = '0;
		pad_buttons = '0;
		last_buttons = '0;
		exp_pressed = '0;
		exp_mask = '0;
		expected_frames = 0;
		lfsr_state = 16'd31;
		repeat (5) @(posedge clk_50M);
		#2;
		rst = 1'b0;
		test_reset_regs();
		test_frame_waveform();
		test_button_capture();
		test_sticky_press();
		test_irq_mask();
		test_periodic_poll();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// ==== tb_pad_model.sv ====
module tb_pad_model (
	input  logic       pad_latch,
	input  logic       pad_pulse,
	input  logic [7:0] buttons,
	output logic       pad_data
);
	timeunit 1ns;
	timeprecision 1ps;

	// Position of the bit now on the data line
	// 8 once all buttons are shifted out
	logic [3:0] bit_pos;

	initial
	begin
		bit_pos = 4'd8;
	end

	////////////////////
	// Pad shift register
	////////////////////

	// Latch loads the buttons, A comes out first
	// Each rising pulse after the latch moves on by one button
	always @(posedge pad_latch or posedge pad_pulse)
	begin
		if (pad_latch)
			bit_pos <= 4'd0;
		else if (bit_pos < 4'd8)
			bit_pos <= bit_pos + 4'd1;
	end

	// Active low, a pressed button pulls the line down
	// Idle or finished pad reads high
	assign pad_data = (bit_pos < 4'd8) ? ~buttons[3'd7 - bit_pos[2:0]] : 1'b1;

endmodule

// ==== vlog.f ====
nes_pad_pkg.sv
nes_pad_reader.sv
pad_events.sv
pad_regs.sv
nes_pad_sub.sv
tb_pad_model.sv
tb_nes_pad_sub.sv
